//--- hdl/lsq_settings.svh
/*
 * Load/store queue settings
 * Widths of data, addresses and tags, and the queue depths
 */
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// Datapath
`define LSQ_DATA_WIDTH 32
`define LSQ_ADDR_WIDTH 16

// Queue depths, store queue kept a power of two
`define LSQ_LQ_DEPTH 4
`define LSQ_SQ_DEPTH 4

// Tags from rename
`define LSQ_ROB_TAG_WIDTH 5
`define LSQ_PRF_TAG_WIDTH 6

`endif

//--- hdl/lsq_core_pkg.sv
/*
 * Load/store queue core types
 * Operations, tags, dispatch bundle, result bus and memory requests
 */
`default_nettype none
`include "lsq_settings.svh"

package lsq_core_pkg;

	typedef logic [`LSQ_DATA_WIDTH-1:0]    data_t;
	typedef logic [`LSQ_ADDR_WIDTH-1:0]    addr_t;
	typedef logic [`LSQ_ROB_TAG_WIDTH-1:0] rob_tag_t;
	typedef logic [`LSQ_PRF_TAG_WIDTH-1:0] prf_tag_t;
	typedef logic [$clog2(`LSQ_SQ_DEPTH):0] sq_ptr_t;  // Index with wrap bit on top

	typedef enum logic [1:0] {
		op_none,
		op_load,
		op_store,
		op_lda     // Address only, no memory access
	} lsq_op_t;

	typedef struct packed {
		logic     valid;
		lsq_op_t  op;
		addr_t    base;
		addr_t    offset;
		data_t    store_data;
		rob_tag_t rob_tag;
		prf_tag_t dest_tag;
	} dispatch_t;

	typedef struct packed {
		logic     valid;
		rob_tag_t rob_tag;
		prf_tag_t dest_tag;
		data_t    value;
	} result_t;

	typedef struct packed {
		logic  valid;
		logic  write;
		addr_t addr;
		data_t wdata;
	} mem_req_t;

endpackage

`default_nettype wire

//--- hdl/lsq_bus_pkg.sv
/*
 * APB bus types
 * Requester side signals, completer response and sequencer states
 */
`default_nettype none

package lsq_bus_pkg;

	typedef struct packed {
		logic                psel;
		logic                penable;
		logic                pwrite;
		lsq_core_pkg::addr_t paddr;
		lsq_core_pkg::data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		logic                pready;
		lsq_core_pkg::data_t prdata;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		apb_idle,
		apb_setup,
		apb_access
	} apb_state_t;

endpackage

`default_nettype wire

//--- hdl/sq_pointers.sv
/*
 * Store queue pointers
 * Head, commit and tail with wrap bits, full and committed flags
 */
`timescale 1ns/1ps
`default_nettype none

module sq_pointers (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  push,
	input  logic                  commit_store,
	input  logic                  write_done,
	input  logic                  flush,
	output lsq_core_pkg::sq_ptr_t head,
	output lsq_core_pkg::sq_ptr_t commit_ptr,
	output lsq_core_pkg::sq_ptr_t tail,
	output logic                  sq_full,
	output logic                  has_committed
);
	localparam int IDX_W = $bits(lsq_core_pkg::sq_ptr_t) - 1;

	lsq_core_pkg::sq_ptr_t commit_next;

	assign commit_next = commit_ptr + lsq_core_pkg::sq_ptr_t'(commit_store);

	always_ff @(posedge clock) begin
		if (reset) begin
			head       <= '0;
			commit_ptr <= '0;
			tail       <= '0;
		end else begin
			head       <= head + lsq_core_pkg::sq_ptr_t'(write_done);  // One write retired
			commit_ptr <= commit_next;
			if (flush)
				tail <= commit_next;  // Uncommitted stores dropped
			else
				tail <= tail + lsq_core_pkg::sq_ptr_t'(push);
		end
	end

	// Same slot, opposite lap
	assign sq_full = (tail[IDX_W] != head[IDX_W]) && (tail[IDX_W-1:0] == head[IDX_W-1:0]);
	assign has_committed = (commit_ptr != head);

endmodule

`default_nettype wire

//--- hdl/store_queue.sv
/*
 * Store queue
 * Holds store address and data in order, offers the head entry
 * as a memory write once it has been committed
 */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
	input  logic                    clock,
	input  logic                    reset,
	input  lsq_core_pkg::dispatch_t dispatch,
	input  lsq_core_pkg::addr_t     addr,
	input  lsq_core_pkg::sq_ptr_t   head,
	input  lsq_core_pkg::sq_ptr_t   tail,
	input  logic                    has_committed,
	output lsq_core_pkg::mem_req_t  write_req
);
	localparam int IDX_W = $bits(lsq_core_pkg::sq_ptr_t) - 1;
	localparam int DEPTH = 1 << IDX_W;

	lsq_core_pkg::addr_t   entry_addr [DEPTH];
	lsq_core_pkg::data_t   entry_data [DEPTH];
	logic [DEPTH-1:0]      entry_valid;
	lsq_core_pkg::sq_ptr_t head_q;      // Head one cycle back
	logic [IDX_W-1:0]      tail_idx;
	logic [IDX_W-1:0]      head_idx;
	logic                  push;

	assign push     = dispatch.valid && (dispatch.op == lsq_core_pkg::op_store);
	assign tail_idx = tail[IDX_W-1:0];
	assign head_idx = head[IDX_W-1:0];

	always_ff @(posedge clock) begin
		if (push) begin
			entry_addr[tail_idx] <= addr;
			entry_data[tail_idx] <= dispatch.store_data;
		end
	end

	//////////////////////////////////////////////////
	// Entry occupancy
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= '0;
			head_q      <= '0;
		end else begin
			head_q <= head;
			if (head != head_q)
				entry_valid[head_q[IDX_W-1:0]] <= 1'b0;  // Slot written out
			if (push)
				entry_valid[tail_idx] <= 1'b1;  // Refill wins over a retire
		end
	end

	// Oldest committed store
	always_comb begin
		write_req.valid = has_committed && entry_valid[head_idx];
		write_req.write = 1'b1;
		write_req.addr  = entry_addr[head_idx];
		write_req.wdata = entry_data[head_idx];
	end

endmodule

`default_nettype wire

//--- hdl/load_queue.sv
/*
 * Load queue
 * Load entries wait for older stores, issue reads in index order,
 * keep returned data and drive the registered result bus
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsq_settings.svh"

module load_queue (
	input  logic                    clock,
	input  logic                    reset,
	input  lsq_core_pkg::dispatch_t dispatch,
	input  lsq_core_pkg::addr_t     addr,
	input  lsq_core_pkg::sq_ptr_t   sq_tail,
	input  lsq_core_pkg::sq_ptr_t   sq_head,
	input  logic                    flush,
	input  logic                    grant,
	input  logic                    read_done,
	input  lsq_core_pkg::data_t     read_data,
	output lsq_core_pkg::mem_req_t  read_req,
	output logic                    lq_full,
	output lsq_core_pkg::result_t   result
);
	localparam int DEPTH = `LSQ_LQ_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	logic [DEPTH-1:0]       valid;
	logic [DEPTH-1:0]       issued;
	logic [DEPTH-1:0]       has_data;
	lsq_core_pkg::addr_t    entry_addr [DEPTH];
	lsq_core_pkg::rob_tag_t entry_rob [DEPTH];
	lsq_core_pkg::prf_tag_t entry_dest [DEPTH];
	lsq_core_pkg::sq_ptr_t  entry_tail [DEPTH];  // Store tail seen at dispatch
	lsq_core_pkg::data_t    entry_data [DEPTH];
	logic [IDX_W-1:0] alloc_idx;
	logic [IDX_W-1:0] issue_idx;
	logic [IDX_W-1:0] ret_idx;
	logic [IDX_W-1:0] wait_idx;                  // Slot of the read in flight
	logic             issue_ok;
	logic             ret_ok;
	logic             ret_free;
	logic             wait_valid;
	logic             push;
	logic             lda;

	assign push     = dispatch.valid && (dispatch.op == lsq_core_pkg::op_load) && !flush;
	assign lda      = dispatch.valid && (dispatch.op == lsq_core_pkg::op_lda);
	assign ret_free = ret_ok && !lda && !flush;  // Load-address owns the bus first
	assign lq_full  = &valid;

	// Lowest index wins in each search
	always_comb begin
		alloc_idx = '0;
		issue_idx = '0;
		issue_ok  = 1'b0;
		ret_idx   = '0;
		ret_ok    = 1'b0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!valid[i])
				alloc_idx = IDX_W'(i);
			if (valid[i] && !issued[i] && (entry_tail[i] == sq_head)) begin
				issue_idx = IDX_W'(i);  // All older stores written
				issue_ok  = 1'b1;
			end
			if (valid[i] && has_data[i]) begin
				ret_idx = IDX_W'(i);
				ret_ok  = 1'b1;
			end
		end
		read_req.valid = issue_ok;
		read_req.write = 1'b0;
		read_req.addr  = entry_addr[issue_idx];
		read_req.wdata = '0;
	end

	//////////////////////////////////////////////////
	// Entry control
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			valid      <= '0;
			issued     <= '0;
			has_data   <= '0;
			wait_valid <= 1'b0;
			wait_idx   <= '0;
		end else begin
			if (grant) begin
				issued[issue_idx] <= 1'b1;
				wait_valid        <= 1'b1;
				wait_idx          <= issue_idx;
			end
			if (read_done && wait_valid) begin
				has_data[wait_idx] <= 1'b1;
				wait_valid         <= 1'b0;
			end
			if (ret_free)
				valid[ret_idx] <= 1'b0;
			if (push) begin
				valid[alloc_idx]    <= 1'b1;
				issued[alloc_idx]   <= 1'b0;
				has_data[alloc_idx] <= 1'b0;
			end
			if (flush) begin
				valid      <= '0;
				wait_valid <= 1'b0;  // Late read data gets dropped
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			entry_addr[alloc_idx] <= addr;
			entry_rob[alloc_idx]  <= dispatch.rob_tag;
			entry_dest[alloc_idx] <= dispatch.dest_tag;
			entry_tail[alloc_idx] <= sq_tail;
		end
		if (read_done && wait_valid)
			entry_data[wait_idx] <= read_data;
	end

	//////////////////////////////////////////////////
	// Result bus
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset)
			result.valid <= 1'b0;
		else
			result.valid <= lda || ret_free;
		if (lda) begin
			result.rob_tag  <= dispatch.rob_tag;
			result.dest_tag <= dispatch.dest_tag;
			result.value    <= lsq_core_pkg::data_t'(addr);  // Effective address
		end else begin
			result.rob_tag  <= entry_rob[ret_idx];
			result.dest_tag <= entry_dest[ret_idx];
			result.value    <= entry_data[ret_idx];
		end
	end

endmodule

`default_nettype wire

//--- hdl/apb_sequencer.sv
/*
 * APB access sequencer
 * Picks a committed store write over a load read, runs setup and
 * access phases and reports completion
 */
`timescale 1ns/1ps
`default_nettype none

module apb_sequencer (
	input  logic                   clock,
	input  logic                   reset,
	input  lsq_core_pkg::mem_req_t write_req,
	input  lsq_core_pkg::mem_req_t read_req,
	input  lsq_bus_pkg::apb_rsp_t  apb_rsp,
	output lsq_bus_pkg::apb_req_t  apb_req,
	output logic                   write_done,
	output logic                   read_grant,
	output logic                   read_done,
	output lsq_core_pkg::data_t    read_data
);
	lsq_bus_pkg::apb_state_t state;
	lsq_core_pkg::mem_req_t  cur;   // Transfer held stable on the bus
	logic                    finish;

	assign read_grant = (state == lsq_bus_pkg::apb_idle) && !write_req.valid && read_req.valid;
	assign finish     = (state == lsq_bus_pkg::apb_access) && apb_rsp.pready;
	assign write_done = finish && cur.write;
	assign read_done  = finish && !cur.write;
	assign read_data  = apb_rsp.prdata;

	//////////////////////////////////////////////////
	// Phase FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lsq_bus_pkg::apb_idle;
		end else begin
			case (state)
				lsq_bus_pkg::apb_idle:
					if (write_req.valid || read_req.valid)
						state <= lsq_bus_pkg::apb_setup;
				lsq_bus_pkg::apb_setup:
					state <= lsq_bus_pkg::apb_access;
				lsq_bus_pkg::apb_access:
					if (apb_rsp.pready)
						state <= lsq_bus_pkg::apb_idle;  // Back to idle for one cycle
				default:
					state <= lsq_bus_pkg::apb_idle;
			endcase
		end
	end

	// Store first
	always_ff @(posedge clock) begin
		if (state == lsq_bus_pkg::apb_idle)
			cur <= write_req.valid ? write_req : read_req;
	end

	always_comb begin
		apb_req.psel    = cur.valid && (state != lsq_bus_pkg::apb_idle);
		apb_req.penable = (state == lsq_bus_pkg::apb_access);
		apb_req.pwrite  = cur.write;
		apb_req.paddr   = cur.addr;
		apb_req.pwdata  = cur.wdata;
	end

endmodule

`default_nettype wire

//--- hdl/lsq_top.sv
/*
 * Load/store queue top
 * Address adder, store pointers, both queues and the APB sequencer
 */
`timescale 1ns/1ps
`default_nettype none

module lsq_top (
	input  logic                    clock,
	input  logic                    reset,
	input  lsq_core_pkg::dispatch_t dispatch,
	input  logic                    commit_store,
	input  logic                    flush,
	input  lsq_bus_pkg::apb_rsp_t   apb_rsp,
	output lsq_bus_pkg::apb_req_t   apb_req,
	output lsq_core_pkg::result_t   result,
	output logic                    lsq_full
);
	lsq_core_pkg::addr_t    addr;
	lsq_core_pkg::sq_ptr_t  sq_head;
	lsq_core_pkg::sq_ptr_t  sq_commit;  // Observed by the bound checker
	lsq_core_pkg::sq_ptr_t  sq_tail;
	lsq_core_pkg::mem_req_t write_req;
	lsq_core_pkg::mem_req_t read_req;
	lsq_core_pkg::data_t    read_data;
	logic sq_push;
	logic sq_full;
	logic sq_has_committed;
	logic lq_full;
	logic write_done;
	logic read_grant;
	logic read_done;

	assign addr     = dispatch.base + dispatch.offset;  // The one address adder
	assign sq_push  = dispatch.valid && (dispatch.op == lsq_core_pkg::op_store);
	assign lsq_full = lq_full || sq_full;

	sq_pointers u_sq_pointers (
		.clock, .reset,
		.push(sq_push), .commit_store, .write_done, .flush,
		.head(sq_head), .commit_ptr(sq_commit), .tail(sq_tail),
		.sq_full, .has_committed(sq_has_committed)
	);

	store_queue u_store_queue (
		.clock, .reset, .dispatch, .addr,
		.head(sq_head), .tail(sq_tail), .has_committed(sq_has_committed),
		.write_req
	);

	load_queue u_load_queue (
		.clock, .reset, .dispatch, .addr,
		.sq_tail, .sq_head, .flush,
		.grant(read_grant), .read_done, .read_data,
		.read_req, .lq_full, .result
	);

	apb_sequencer u_apb_sequencer (
		.clock, .reset, .write_req, .read_req, .apb_rsp, .apb_req,
		.write_done, .read_grant, .read_done, .read_data
	);

endmodule

`default_nettype wire

//--- dv/lsq_asserts.sv
/*
 * Load/store queue checker
 * APB phase and signal stability, dispatcher back-pressure and commit rules
 */
`timescale 1ns/1ps
`default_nettype none

module lsq_asserts (
	input logic                    clock,
	input logic                    reset,
	input lsq_bus_pkg::apb_req_t   apb_req,
	input lsq_bus_pkg::apb_rsp_t   apb_rsp,
	input lsq_core_pkg::dispatch_t dispatch,
	input logic                    commit_store,
	input lsq_core_pkg::sq_ptr_t   sq_commit,
	input lsq_core_pkg::sq_ptr_t   sq_tail,
	input logic                    lsq_full
);
	// Setup is always followed by access
	setup_then_access: assert property (@(posedge clock) disable iff (reset)
		apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
		else $error("APB setup phase not followed by access phase");

	// Transfer held until pready
	held_until_ready: assert property (@(posedge clock) disable iff (reset)
		apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=>
			apb_req.psel && $stable(apb_req.paddr) && $stable(apb_req.pwrite)
			&& $stable(apb_req.pwdata))
		else $error("APB transfer changed before completion");

	// Commit only while an uncommitted store is queued
	commit_has_store: assert property (@(posedge clock) disable iff (reset)
		commit_store |-> sq_commit != sq_tail)
		else $error("store commit with no uncommitted store");

	no_push_when_full: assert property (@(posedge clock) disable iff (reset)
		dispatch.valid && (dispatch.op inside {lsq_core_pkg::op_load, lsq_core_pkg::op_store})
			|-> !lsq_full)
		else $error("load or store dispatched while queue full");

endmodule

bind lsq_top lsq_asserts u_asserts (.*);

`default_nettype wire

//--- dv/lsq_tb.sv
/*
 * Load/store queue testbench
 * APB memory model, dispatch stimulus, reference model and result checks
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsq_settings.svh"

module lsq_tb;
	localparam int MEM_WORDS = 64;
	localparam int TIMEOUT   = 2000;

	logic                    clock;
	logic                    reset;
	lsq_core_pkg::dispatch_t dispatch;
	logic                    commit_store;
	logic                    flush;
	lsq_bus_pkg::apb_rsp_t   apb_rsp;
	lsq_bus_pkg::apb_req_t   apb_req;
	lsq_core_pkg::result_t   result;
	logic                    lsq_full;

	lsq_core_pkg::data_t mem [MEM_WORDS];
	lsq_core_pkg::data_t shadow [MEM_WORDS];     // Memory as seen in program order
	lsq_core_pkg::data_t exp_value [32];
	lsq_core_pkg::prf_tag_t exp_dest [32];
	logic [31:0] exp_pending;                    // One bit per rob tag
	logic [47:0] exp_writes [$];                 // Committed stores, address and data
	logic [47:0] pend_stores [$];                // Dispatched, not yet committed
	lsq_core_pkg::rob_tag_t rob_next;
	int   errors;
	int   checks;
	int   tests;
	int   wait_cnt;
	int   max_delay;
	logic hold_ready;

	always #50 clock = ~clock;

	lsq_top uut (.*);

	function automatic lsq_core_pkg::data_t preset(int i);
		return 32'h5a00_0000 + i * 32'h0001_0203;
	endfunction

	// Reference model
	function automatic lsq_core_pkg::data_t expected_result(lsq_core_pkg::lsq_op_t op,
			lsq_core_pkg::addr_t a);
		if (op == lsq_core_pkg::op_lda)
			return lsq_core_pkg::data_t'(a);
		return shadow[a[5:0]];
	endfunction

	task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report(string msg);
		errors++;
		$display("error: %s", msg);
	endtask

	//////////////////////////////////////////////////
	// APB memory model
	//////////////////////////////////////////////////
	always @(negedge clock) begin
		apb_rsp.prdata = mem[apb_req.paddr[5:0]];
		if (!apb_req.psel || hold_ready) begin
			apb_rsp.pready = 1'b0;
		end else if (!apb_req.penable) begin
			apb_rsp.pready = 1'b0;
			wait_cnt = $urandom_range(max_delay, 0);  // Random wait states
		end else if (wait_cnt == 0) begin
			apb_rsp.pready = 1'b1;  // Transfer ends at the next rising edge
			if (apb_req.pwrite) begin
				if (exp_writes.size() == 0) begin
					report("APB write with no committed store outstanding");
				end else begin
					check("apb write", exp_writes[0], {apb_req.paddr, apb_req.pwdata});
					void'(exp_writes.pop_front());
				end
				mem[apb_req.paddr[5:0]] = apb_req.pwdata;
			end
		end else begin
			wait_cnt--;
		end
	end

	// Compare each result against the reference by rob tag
	always @(negedge clock) begin
		if (!reset && result.valid) begin
			if (!exp_pending[result.rob_tag]) begin
				report($sformatf("unexpected result for rob tag %0d", result.rob_tag));
			end else begin
				check($sformatf("rob %0d value", result.rob_tag),
					exp_value[result.rob_tag], result.value);
				check($sformatf("rob %0d dest", result.rob_tag),
					exp_dest[result.rob_tag], result.dest_tag);
				exp_pending[result.rob_tag] = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////
	task automatic send(lsq_core_pkg::lsq_op_t op, lsq_core_pkg::addr_t base,
			lsq_core_pkg::addr_t offset, lsq_core_pkg::data_t data);
		lsq_core_pkg::addr_t a;
		int n;
		a = base + offset;
		n = 0;
		@(negedge clock);
		while (op != lsq_core_pkg::op_lda && lsq_full && n < TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		if (n >= TIMEOUT)
			report("timeout waiting for the queue to leave full");
		dispatch.valid      = 1'b1;
		dispatch.op         = op;
		dispatch.base       = base;
		dispatch.offset     = offset;
		dispatch.store_data = data;
		dispatch.rob_tag    = rob_next;
		dispatch.dest_tag   = {1'b0, rob_next} + 6'd7;
		if (op == lsq_core_pkg::op_store) begin
			pend_stores.push_back({a, data});
		end else begin
			exp_value[rob_next]   = expected_result(op, a);
			exp_dest[rob_next]    = {1'b0, rob_next} + 6'd7;
			exp_pending[rob_next] = 1'b1;
		end
		rob_next++;
		@(negedge clock);
		dispatch.valid = 1'b0;
		dispatch.op    = lsq_core_pkg::op_none;
	endtask

	task automatic commit_one();
		logic [47:0] s;
		@(negedge clock);
		commit_store = 1'b1;
		if (pend_stores.size() != 0) begin
			s = pend_stores.pop_front();
			shadow[s[37:32]] = s[31:0];  // Store becomes architectural
			exp_writes.push_back(s);
		end
		@(negedge clock);
		commit_store = 1'b0;
	endtask

	task automatic flush_all();
		@(negedge clock);
		flush = 1'b1;
		pend_stores.delete();
		exp_pending = '0;
		@(negedge clock);
		flush = 1'b0;
	endtask

	task automatic wait_idle(string what);
		int n;
		n = 0;
		while ((exp_pending != 0 || exp_writes.size() != 0) && n < TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		if (n >= TIMEOUT)
			report($sformatf("timeout waiting for %s", what));
	endtask

	task automatic end_test(string name, int errors_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		int e;
		int kind;
		lsq_core_pkg::addr_t a;
		void'($urandom(32'hfc71));
		clock        = 1'b0;
		reset        = 1'b1;
		dispatch     = '0;
		commit_store = 1'b0;
		flush        = 1'b0;
		apb_rsp      = '0;
		hold_ready   = 1'b0;
		max_delay    = 0;
		wait_cnt     = 0;
		exp_pending  = '0;
		rob_next     = '0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]    = preset(i);
			shadow[i] = preset(i);
		end
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		e = errors;
		send(lsq_core_pkg::op_lda, 16'h1200, 16'h0034, '0);
		check("lda valid next cycle", 1, result.valid);
		check("lda rob tag", rob_next - 1'b1, result.rob_tag);
		wait_idle("load-address result");
		end_test("load-address", e);

		e = errors;
		send(lsq_core_pkg::op_store, 16'h0010, 16'h0000, 32'haaaa_5555);
		commit_one();
		send(lsq_core_pkg::op_load, 16'h0008, 16'h0008, '0);
		send(lsq_core_pkg::op_load, 16'h0021, 16'h0000, '0);  // Untouched word
		wait_idle("store then load");
		end_test("store to load", e);

		e = errors;
		for (int i = 3; i < 6; i++)
			send(lsq_core_pkg::op_store, lsq_core_pkg::addr_t'(i), 16'h0000, 32'hbeef_0000 + i);
		repeat (6) @(negedge clock);
		check("no write before commit", preset(3), mem[3]);
		repeat (3) commit_one();
		wait_idle("committed store writes");
		for (int i = 3; i < 6; i++)
			check($sformatf("memory word %0d", i), shadow[i], mem[i]);
		end_test("store order", e);

		e = errors;
		max_delay = 4;
		for (int k = 0; k < 16; k++) begin
			kind = $urandom_range(2, 0);
			a    = lsq_core_pkg::addr_t'($urandom_range(MEM_WORDS - 1, 0));
			if (kind == 0) begin
				send(lsq_core_pkg::op_lda, a, 16'h0100, '0);
			end else if (kind == 1) begin
				send(lsq_core_pkg::op_load, a, 16'h0000, '0);
			end else begin
				send(lsq_core_pkg::op_store, a, 16'h0000, $urandom());
				wait_idle("older loads before commit");
				commit_one();
			end
		end
		wait_idle("random traffic");
		end_test("random pready", e);

		e = errors;
		send(lsq_core_pkg::op_store, 16'h0008, 16'h0000, 32'h1111_2222);
		commit_one();
		send(lsq_core_pkg::op_store, 16'h0009, 16'h0000, 32'h3333_4444);
		send(lsq_core_pkg::op_load, 16'h0009, 16'h0000, '0);
		flush_all();
		wait_idle("committed store after flush");
		repeat (10) @(negedge clock);
		send(lsq_core_pkg::op_load, 16'h0009, 16'h0000, '0);
		send(lsq_core_pkg::op_load, 16'h0008, 16'h0000, '0);
		wait_idle("loads after flush");
		end_test("flush", e);

		e = errors;
		hold_ready = 1'b1;
		for (int i = 0; i < `LSQ_LQ_DEPTH; i++)
			send(lsq_core_pkg::op_load, lsq_core_pkg::addr_t'(40 + i), 16'h0000, '0);
		check("full with loads stalled", 1, lsq_full);
		hold_ready = 1'b0;
		wait_idle("stalled loads");
		@(negedge clock);
		check("full released", 0, lsq_full);
		end_test("queue full", e);

		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/lsq_core_pkg.sv
hdl/lsq_bus_pkg.sv
hdl/sq_pointers.sv
hdl/store_queue.sv
hdl/load_queue.sv
hdl/apb_sequencer.sv
hdl/lsq_top.sv
dv/lsq_asserts.sv
dv/lsq_tb.sv

//--- Makefile
# Verilator build and run for the load/store queue testbench

VERILATOR ?= verilator
TOP       ?= lsq_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
PASS_TEXT ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
